/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

	localparam int DATA_WIDTH = 16;
	localparam int REG_ADDR_WIDTH = 4;

	// Major opcodes in bits 15..12
	typedef enum logic [3:0] {
		OP_RTYPE = 4'h0,
		OP_ADDI  = 4'h1,
		OP_MOVI  = 4'h2,
		OP_LUI   = 4'h3
	} opcodeT;

	// ALU operations that double as the R-type opExt field
	typedef enum logic [3:0] {
		ALU_ADD = 4'h0,
		ALU_SUB = 4'h1,
		ALU_AND = 4'h2,
		ALU_OR  = 4'h3,
		ALU_XOR = 4'h4,
		ALU_MOV = 4'h5,
		ALU_LUI = 4'h6
	} aluOpT;

	// Source of ALU operand B
	typedef enum logic [1:0] {
		IMM_NONE = 2'd0,
		IMM_SEXT = 2'd1,
		IMM_ZEXT = 2'd2
	} immModeT;

	typedef struct packed {
		opcodeT opcode;
		logic [REG_ADDR_WIDTH-1:0] rDest;
		aluOpT opExt;
		logic [REG_ADDR_WIDTH-1:0] rSrc;
	} rTypeT;

	typedef struct packed {
		opcodeT opcode;
		logic [REG_ADDR_WIDTH-1:0] rDest;
		logic [7:0] imm;
	} iTypeT;

	// The opcode picks which view of the word applies
	typedef union packed {
		rTypeT r;
		iTypeT i;
	} instrWordT;

endpackage

`default_nettype wire

/* registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile import cpuPkg::*;
(
	input  wire logic Clk,
	input  wire logic arstN,
	input  wire logic writeEnable,
	input  wire logic [REG_ADDR_WIDTH-1:0] writeAddr,
	input  wire logic [REG_ADDR_WIDTH-1:0] readAddrA,
	input  wire logic [REG_ADDR_WIDTH-1:0] readAddrB,
	input  wire logic [DATA_WIDTH-1:0] writeData,
	output logic [DATA_WIDTH-1:0] regA,
	output logic [DATA_WIDTH-1:0] regB
);

	localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] regs [NUM_REGS];

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int k = 0; k < NUM_REGS; k++)
			begin
				regs[k] <= '0;
			end
		end
		else if (writeEnable)
		begin
			regs[writeAddr] <= writeData;
		end
	end

	//////////////////////////////////////////////////
	// Registered read ports
	//////////////////////////////////////////////////

	// Same-edge write is not visible until the next read
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			regA <= '0;
			regB <= '0;
		end
		else
		begin
			regA <= regs[readAddrA];
			regB <= regs[readAddrB];
		end
	end

endmodule

`default_nettype wire

/* instrQueue.sv */
`timescale 1ns/1ns
`default_nettype none

module instrQueue import cpuPkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  wire logic Clk,
	input  wire logic arstN,
	input  wire logic instrValid,
	input  wire instrWordT instr,
	input  wire logic pop,
	output instrWordT headInstr,
	output logic queueEmpty,
	output logic creditReturn
);

	localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

	instrWordT mem [QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	logic [PTR_WIDTH:0] count;
	logic doPop;

	// Pop from an empty queue is ignored
	assign doPop = pop && !queueEmpty;
	assign queueEmpty = (count == '0);
	assign headInstr = mem[rdPtr];

	// Storage
	always_ff @(posedge Clk)
	begin
		if (instrValid)
		begin
			mem[wrPtr] <= instr;
		end
	end

	//////////////////////////////////////////////////
	// Pointers, occupancy and credit return
	//////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			// Pointers wrap since depth is a power of two
			if (instrValid)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + (instrValid ? 1'b1 : 1'b0) - (doPop ? 1'b1 : 1'b0);
			creditReturn <= doPop;
		end
	end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import cpuPkg::*;
(
	input  wire aluOpT aluOp,
	input  wire immModeT immMode,
	input  wire logic [7:0] imm,
	input  wire logic [DATA_WIDTH-1:0] opA,
	input  wire logic [DATA_WIDTH-1:0] opB,
	output logic [DATA_WIDTH-1:0] result
);

	logic [DATA_WIDTH-1:0] effB;

	//////////////////////////////////////////////////
	// Operand B select
	//////////////////////////////////////////////////

	always_comb
	begin
		case (immMode)
			IMM_SEXT:
				effB = {{(DATA_WIDTH-8){imm[7]}}, imm};
			IMM_ZEXT:
				effB = {{(DATA_WIDTH-8){1'b0}}, imm};
			default:
				effB = opB;
		endcase
	end

	//////////////////////////////////////////////////
	// Operation
	//////////////////////////////////////////////////

	// Add and subtract wrap at the word width
	always_comb
	begin
		case (aluOp)
			ALU_ADD:
				result = opA + effB;
			ALU_SUB:
				result = opA - effB;
			ALU_AND:
				result = opA & effB;
			ALU_OR:
				result = opA | effB;
			ALU_XOR:
				result = opA ^ effB;
			ALU_MOV:
				result = effB;
			ALU_LUI:
				result = effB << 8;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit import cpuPkg::*;
(
	input  wire logic Clk,
	input  wire logic arstN,
	input  wire logic queueEmpty,
	input  wire instrWordT headInstr,
	output logic pop,
	output logic [REG_ADDR_WIDTH-1:0] readAddrA,
	output logic [REG_ADDR_WIDTH-1:0] readAddrB,
	output logic [REG_ADDR_WIDTH-1:0] writeAddr,
	output logic writeEnable,
	output aluOpT aluOp,
	output immModeT immMode,
	output logic [7:0] imm
);

	localparam logic ISSUE = 1'b0;
	localparam logic EXEC = 1'b1;

	logic state;
	instrWordT instrReg;
	logic opValid;

	//////////////////////////////////////////////////
	// Issue side
	//////////////////////////////////////////////////

	// Register file sees the head entry while in ISSUE
	assign pop = (state == ISSUE) && !queueEmpty;
	assign readAddrA = headInstr.r.rDest;
	assign readAddrB = headInstr.r.rSrc;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			state <= ISSUE;
		else if (state == EXEC)
			state <= ISSUE;
		else if (pop)
			state <= EXEC;
	end

	always_ff @(posedge Clk)
	begin
		if (pop)
			instrReg <= headInstr;
	end

	//////////////////////////////////////////////////
	// Decode of the latched word
	//////////////////////////////////////////////////

	always_comb
	begin
		aluOp = ALU_ADD;
		immMode = IMM_NONE;
		opValid = 1'b0;
		case (instrReg.r.opcode)
			OP_RTYPE:
			begin
				aluOp = instrReg.r.opExt;
				opValid = instrReg.r.opExt inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
					ALU_XOR, ALU_MOV, ALU_LUI};
			end
			OP_ADDI:
			begin
				immMode = IMM_SEXT;
				opValid = 1'b1;
			end
			OP_MOVI:
			begin
				aluOp = ALU_MOV;
				immMode = IMM_ZEXT;
				opValid = 1'b1;
			end
			OP_LUI:
			begin
				aluOp = ALU_LUI;
				immMode = IMM_ZEXT;
				opValid = 1'b1;
			end
			default:
				opValid = 1'b0;
		endcase
	end

	// Unknown words are dropped without a write
	assign writeEnable = (state == EXEC) && opValid;
	assign writeAddr = instrReg.i.rDest;
	assign imm = instrReg.i.imm;

endmodule

`default_nettype wire

/* datapathTop.sv */
`timescale 1ns/1ns
`default_nettype none

module datapathTop import cpuPkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  wire logic Clk,
	input  wire logic arstN,
	input  wire logic instrValid,
	input  wire logic [DATA_WIDTH-1:0] instr,
	output logic creditReturn,
	output logic resultValid,
	output logic [REG_ADDR_WIDTH-1:0] resultReg,
	output logic [DATA_WIDTH-1:0] resultData
);

	instrWordT headInstr;
	logic queueEmpty;
	logic pop;
	logic [REG_ADDR_WIDTH-1:0] readAddrA;
	logic [REG_ADDR_WIDTH-1:0] readAddrB;
	aluOpT aluOp;
	immModeT immMode;
	logic [7:0] imm;
	logic [DATA_WIDTH-1:0] regA;
	logic [DATA_WIDTH-1:0] regB;

	instrQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
		.Clk(Clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
		.pop(pop), .headInstr(headInstr), .queueEmpty(queueEmpty),
		.creditReturn(creditReturn)
	);

	// Write-back port doubles as the trace
	controlUnit control_i (
		.Clk(Clk), .arstN(arstN), .queueEmpty(queueEmpty), .headInstr(headInstr),
		.pop(pop), .readAddrA(readAddrA), .readAddrB(readAddrB),
		.writeAddr(resultReg), .writeEnable(resultValid),
		.aluOp(aluOp), .immMode(immMode), .imm(imm)
	);

	registerFile regFile_i (
		.Clk(Clk), .arstN(arstN), .writeEnable(resultValid), .writeAddr(resultReg),
		.readAddrA(readAddrA), .readAddrB(readAddrB), .writeData(resultData),
		.regA(regA), .regB(regB)
	);

	alu alu_i (
		.aluOp(aluOp), .immMode(immMode), .imm(imm),
		.opA(regA), .opB(regB), .result(resultData)
	);

endmodule

`default_nettype wire

/* tbDatapath.sv */
`timescale 1ns/1ns
`default_nettype none

module tbDatapath;

	localparam int QUEUE_DEPTH = 4;
	localparam int MAX_LINES = 64;
	localparam int WAIT_LIMIT = 200;

	logic Clk;
	logic arstN;
	logic instrValid;
	logic [15:0] instr;
	logic creditReturn;
	logic resultValid;
	logic [3:0] resultReg;
	logic [15:0] resultData;

	logic [15:0] instrList [MAX_LINES];
	logic [3:0] expRegList [MAX_LINES];
	logic [15:0] expDataList [MAX_LINES];
	int numInstr;
	int numExpected;
	int resultIdx;
	int credits;
	int valueErrors;
	int otherErrors;
	bit sawFull;
	bit aborted;
	logic [31:0] rngState;

	datapathTop #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (
		.Clk(Clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
		.creditReturn(creditReturn), .resultValid(resultValid),
		.resultReg(resultReg), .resultData(resultData)
	);

	always #10 Clk = ~Clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Writing lines fill the expected trace in file order
	task automatic loadTestData();
		int fd;
		int items;
		logic [15:0] word;
		logic [3:0] writes;
		logic [3:0] dest;
		logic [15:0] data;
		logic [8*120-1:0] line;
		fd = $fopen("datapath_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the test data file");
			otherErrors++;
			aborted = 1'b1;
		end
		else
		begin
			line = '0;
			while ($fgets(line, fd) != 0 && numInstr < MAX_LINES)
			begin
				items = $sscanf(line, "%h %h %h %h", word, writes, dest, data);
				if (items == 4)
				begin
					instrList[numInstr] = word;
					numInstr++;
					if (writes != 0)
					begin
						expRegList[numExpected] = dest;
						expDataList[numExpected] = data;
						numExpected++;
					end
				end
				line = '0;
			end
			$fclose(fd);
		end
	endtask

	// Wait one clock edge and collect any returned credit
	task automatic tick();
		@(posedge Clk);
		if (creditReturn)
		begin
			credits++;
			if (credits > QUEUE_DEPTH)
			begin
				$display("Credit count rose above the queue depth at time %0t", $time);
				otherErrors++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Write-back trace monitor
	//////////////////////////////////////////////////

	always @(posedge Clk)
	begin
		if (arstN && resultValid)
		begin
			if (resultIdx >= numExpected)
			begin
				$display("Unexpected write-back at time %0t", $time);
				otherErrors++;
			end
			else
			begin
				if (resultReg !== expRegList[resultIdx])
				begin
					$display("** Error at time %0t: resultReg = %h, expected %h",
						$time, resultReg, expRegList[resultIdx]);
					valueErrors++;
				end
				if (resultData !== expDataList[resultIdx])
				begin
					$display("** Error at time %0t: resultData = %h, expected %h",
						$time, resultData, expDataList[resultIdx]);
					valueErrors++;
				end
			end
			resultIdx++;
		end
	end

	//////////////////////////////////////////////////
	// Sender with credit counter
	//////////////////////////////////////////////////

	initial
	begin
		int gap;
		int waited;
		Clk = 1'b0;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		numInstr = 0;
		numExpected = 0;
		resultIdx = 0;
		credits = QUEUE_DEPTH;
		valueErrors = 0;
		otherErrors = 0;
		sawFull = 1'b0;
		aborted = 1'b0;
		rngState = 32'h44d2;
		loadTestData();
		repeat (5) @(posedge Clk);
		arstN <= 1'b1;
		for (int n = 0; n < numInstr && !aborted; n++)
		begin
			rngState = xorshift32(rngState);
			// Opening burst fills the queue
			gap = (n < 8) ? 0 : int'(rngState[1:0]);
			for (int g = 0; g < gap; g++)
			begin
				tick();
				instrValid <= 1'b0;
			end
			tick();
			waited = 0;
			while (credits == 0 && waited < WAIT_LIMIT)
			begin
				instrValid <= 1'b0;
				tick();
				waited++;
			end
			if (credits == 0)
			begin
				$display("Timed out waiting for a credit");
				otherErrors++;
				aborted = 1'b1;
			end
			else
			begin
				instrValid <= 1'b1;
				instr <= instrList[n];
				credits--;
				if (credits == 0)
					sawFull = 1'b1;
			end
		end
		tick();
		instrValid <= 1'b0;

		// All credits come back once every word is consumed
		waited = 0;
		while (!aborted && credits != QUEUE_DEPTH && waited < WAIT_LIMIT)
		begin
			tick();
			waited++;
		end
		if (!aborted && credits != QUEUE_DEPTH)
		begin
			$display("Timed out waiting for all credits, %0d of %0d back", credits, QUEUE_DEPTH);
			otherErrors++;
			aborted = 1'b1;
		end
		waited = 0;
		while (!aborted && resultIdx < numExpected && waited < WAIT_LIMIT)
		begin
			tick();
			waited++;
		end
		if (!aborted && resultIdx != numExpected)
		begin
			$display("Saw %0d write-backs, expected %0d", resultIdx, numExpected);
			otherErrors++;
		end
		if (!aborted && !sawFull)
		begin
			$display("The queue never filled during the burst");
			otherErrors++;
		end

		$display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
cpuPkg.sv
registerFile.sv
instrQueue.sv
alu.sv
controlUnit.sv
datapathTop.sv
tbDatapath.sv

/* datapath_testdata.txt */
# instr(hex) writes(1/0) dest(hex) data(hex), one instruction per line
# lines with writes = 0 are consumed without a write-back
0152 1 1 0000
0304 1 3 0000
217F 1 1 007F
2285 1 2 0085
0102 1 1 0104
0311 1 3 FEFC
0322 1 3 0084
0231 1 2 0185
0142 1 1 0081
34A5 1 4 A500
14FF 1 4 A4FF
1580 1 5 FF80
7123 0 0 0000
0654 1 6 A4FF
06F4 0 0 0000
1601 1 6 A500
0715 1 7 0080
3FFF 1 F FF00
0F06 1 F A400
C000 0 0 0000
283C 1 8 003C
084F 1 8 A43C
